// File: Bender.yml
package:
  name: lsu

sources:
  - verilog/lsuPkg.sv
  - verilog/lsuControl.sv
  - verilog/storeAligner.sv
  - verilog/dataMem.sv
  - verilog/loadExtractor.sv
  - verilog/lsuTop.sv
  - target: simulation
    files:
      - verification/lsuTb.sv

// File: sim.f
verilog/lsuPkg.sv
verilog/lsuControl.sv
verilog/storeAligner.sv
verilog/dataMem.sv
verilog/loadExtractor.sv
verilog/lsuTop.sv
verification/lsuTb.sv

// File: verification/lsuStim.txt
# test isStore func3 addr wdata expRdata expFault
# all fields after the test name are hex
sw_word0 1 2 00000000 0badf00d 00000000 0
sw_word 1 2 00000100 deadbeef 00000000 0
lw_word 0 2 00000100 00000000 deadbeef 0
sw_word2 1 2 00000104 12345678 00000000 0
lw_word2 0 2 00000104 00000000 12345678 0
sb_off0 1 0 00000108 000000a1 00000000 0
sb_off1 1 0 00000109 ffffffb2 00000000 0
sb_off2 1 0 0000010a 000000c3 00000000 0
sb_off3 1 0 0000010b 123456d4 00000000 0
lw_bytes 0 2 00000108 00000000 d4c3b2a1 0
lb_off0 0 0 00000108 00000000 ffffffa1 0
lb_off1 0 0 00000109 00000000 ffffffb2 0
lb_off2 0 0 0000010a 00000000 ffffffc3 0
lb_off3 0 0 0000010b 00000000 ffffffd4 0
lbu_off0 0 4 00000108 00000000 000000a1 0
lbu_off1 0 4 00000109 00000000 000000b2 0
lbu_off2 0 4 0000010a 00000000 000000c3 0
lbu_off3 0 4 0000010b 00000000 000000d4 0
lh_off0 0 1 00000108 00000000 ffffb2a1 0
lh_off1 0 1 00000109 00000000 ffffc3b2 0
lh_off2 0 1 0000010a 00000000 ffffd4c3 0
lhu_off0 0 5 00000108 00000000 0000b2a1 0
lhu_off1 0 5 00000109 00000000 0000c3b2 0
lhu_off2 0 5 0000010a 00000000 0000d4c3 0
lb_pos 0 0 00000104 00000000 00000078 0
lh_pos 0 1 00000106 00000000 00001234 0
sw_base 1 2 0000010c 11223344 00000000 0
sh_off1 1 1 0000010d 9999aabb 00000000 0
lw_after_sh 0 2 0000010c 00000000 11aabb44 0
lw_off2 0 2 0000010e 00000000 00000000 1
sh_off3 1 1 0000010f 0000ffff 00000000 1
ld_f3_3 0 3 00000100 00000000 00000000 1
st_f3_6 1 6 00000100 cafef00d 00000000 1
st_f3_4 1 4 00000100 cafef00d 00000000 1
sw_idx1024 1 2 00001000 cafef00d 00000000 1
lw_after_f3 0 2 00000100 00000000 deadbeef 0
lw_after_sh3 0 2 0000010c 00000000 11aabb44 0
lw_word0 0 2 00000000 00000000 0badf00d 0

// File: verification/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;
  import lsuPkg::*;

  localparam int DepthWords = 1024;
  localparam int ClkPeriod = 10;
  localparam int ResetCycles = 5;
  localparam string StimPath = "verification/lsuStim.txt";

  logic clk;
  logic arstN;
  logic reqValid;
  memReqT req;
  logic respValid;
  memRespT resp;

  // one entry per stimulus line, in file order
  string stimName[$];
  memReqT stimReq[$];
  logic [31:0] stimRdata[$];
  logic stimFault[$];
  bit stimLoaded = 1'b0;

  // responses still owed by the DUT, oldest first
  string pendName[$];
  logic [31:0] pendRdata[$];
  logic pendFault[$];
  logic respDue = 1'b0;  // a request was presented last cycle

  lsuTop #(
    .DepthWords(DepthWords)
  ) dut0 (
    .clk(clk),
    .arstN(arstN),
    .reqValid(reqValid),
    .req(req),
    .respValid(respValid),
    .resp(resp)
  );

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  task automatic stopOnFailure();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic checkValue(
    input string testName,
    input string what,
    input logic [31:0] expected,
    input logic [31:0] actual
  );
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %08h, actual %08h", testName, what, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic loadStimulus();
    int fd;
    int fields;
    string line;
    string name;
    logic [31:0] isStore;
    logic [31:0] func3;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] expRdata;
    logic [31:0] expFault;
    memReqT entry;
    fd = $fopen(StimPath, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", StimPath);
      stopOnFailure();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() == 0) continue;
      if (line[0] == "#" || line[0] == "\n" || line[0] == "\r") continue;  // comments, blanks
      fields = $sscanf(line, "%s %h %h %h %h %h %h",
                       name, isStore, func3, addr, wdata, expRdata, expFault);
      if (fields != 7) begin
        $display("stimulus line has %0d fields instead of 7: %s", fields, line);
        stopOnFailure();
      end
      entry.isStore = isStore[0];
      entry.func3 = func3[Func3Width-1:0];
      entry.addr = addr;
      entry.wdata = wdata;
      stimName.push_back(name);
      stimReq.push_back(entry);
      stimRdata.push_back(expRdata);
      stimFault.push_back(expFault[0]);
    end
    $fclose(fd);
  endtask

  // reset, then one request per cycle with no gaps
  initial begin
    arstN = 1'b0;
    reqValid = 1'b0;
    req = '0;
    loadStimulus();
    stimLoaded = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1;
    foreach (stimReq[i]) begin
      @(posedge clk);
      reqValid <= 1'b1;
      req <= stimReq[i];
      pendName.push_back(stimName[i]);
      pendRdata.push_back(stimRdata[i]);
      pendFault.push_back(stimFault[i]);
    end
    @(posedge clk);
    reqValid <= 1'b0;
    req <= '0;
    repeat (3) @(posedge clk);  // let the last response drain
    if (pendName.size() != 0) begin
      $display("%0d responses never arrived", pendName.size());
      stopOnFailure();
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // outputs are registered, so mid-cycle they are settled
  always @(negedge clk) begin
    if (arstN) begin
      if (respDue && respValid !== 1'b1) begin
        $display("no response one cycle after the request for %s",
                 pendName.size() != 0 ? pendName[0] : "an unknown test");
        stopOnFailure();
      end
      if (respValid === 1'b1) begin
        if (pendName.size() == 0) begin
          $display("a response arrived with no request outstanding");
          stopOnFailure();
        end else begin
          checkValue(pendName[0], "rdata", pendRdata[0], resp.rdata);
          checkValue(pendName[0], "fault", {31'b0, pendFault[0]}, {31'b0, resp.fault});
          pendName.delete(0);
          pendRdata.delete(0);
          pendFault.delete(0);
        end
      end
      respDue = reqValid;  // seen by the DUT at the coming edge
    end
  end

  // run length follows the number of stimulus lines
  initial begin
    int limitNs;
    wait (stimLoaded);
    limitNs = (stimReq.size() + 20) * ClkPeriod;
    #(limitNs);
    $display("timeout after %0d ns, the run did not finish in time", limitNs);
    stopOnFailure();
  end

endmodule

// File: verilog/dataMem.sv
`timescale 1ns/1ps

module dataMem #(
  parameter int DepthWords = 1024
) (
  input  logic clk,
  input  lsuPkg::memWriteT memWrite,
  input  logic [$clog2(DepthWords)-1:0] rdIdx,
  output logic [31:0] rdWord
);
  import lsuPkg::*;

  localparam int IdxWidth = $clog2(DepthWords);
  localparam int BytesPerWord = DataWidth / 8;

  logic [DataWidth-1:0] mem [DepthWords];
  logic [IdxWidth-1:0] wrIdx;

  assign wrIdx = memWrite.wordIdx[IdxWidth-1:0];

  // per-byte write on the rising edge
  always_ff @(posedge clk) begin
    for (int i = 0; i < BytesPerWord; i++) begin
      if (memWrite.byteEn[i]) begin
        mem[wrIdx][i*8 +: 8] <= memWrite.lanes[i*8 +: 8];
      end
    end
  end

  // registered read, next-cycle load sees this edge's store
  always_ff @(posedge clk) begin
    rdWord <= mem[rdIdx];
  end

  // range check lives in the control block, writes must never alias
  noWriteOutOfRange: assert property (
    @(posedge clk)
    (memWrite.byteEn != '0) |-> (memWrite.wordIdx < DepthWords)
  ) else $error("write enabled at word %0d beyond depth %0d",
                memWrite.wordIdx, DepthWords);

endmodule

// File: verilog/loadExtractor.sv
`timescale 1ns/1ps

module loadExtractor (
  input  lsuPkg::stageMetaT meta,
  input  logic [31:0] rdWord,
  output logic [31:0] rdata
);

  logic [31:0] shifted;
  logic fillByte;
  logic fillHalf;

  // addressed byte lands in bits 7:0
  assign shifted = rdWord >> {meta.offset, 3'b000};

  // sign bits, zero for lbu and lhu
  assign fillByte = !meta.isUnsigned && shifted[7];
  assign fillHalf = !meta.isUnsigned && shifted[15];

  always_comb begin
    if (!meta.isLoad || meta.fault) begin
      rdata = 32'b0;  // stores and refused accesses
    end else begin
      case (meta.size)
        2'd0: rdata = {{24{fillByte}}, shifted[7:0]};  // lb lbu
        2'd1: rdata = {{16{fillHalf}}, shifted[15:0]};  // lh lhu
        default: rdata = shifted;  // lw, offset is zero here
      endcase
    end
  end

endmodule

// File: verilog/lsuControl.sv
`timescale 1ns/1ps

module lsuControl #(
  parameter int DepthWords = 1024
) (
  input  logic clk,
  input  logic arstN,
  input  logic reqValid,
  input  lsuPkg::memReqT req,
  input  logic [3:0] byteEn,
  input  logic [31:0] lanes,
  output logic [1:0] alignSize,
  output logic [1:0] alignOffset,
  output lsuPkg::memWriteT memWrite,
  output logic [$clog2(DepthWords)-1:0] rdIdx,
  output lsuPkg::stageMetaT meta,
  output logic respValid,
  output logic respFault
);
  import lsuPkg::*;

  localparam int IdxWidth = $clog2(DepthWords);
  localparam logic [AddrWidth-3:0] DepthLimit = (AddrWidth-2)'(DepthWords);

  logic [AddrWidth-3:0] wordAddr;
  logic [1:0] offset;
  logic [1:0] size;
  logic [2:0] accessBytes;
  logic func3Ok;
  logic aligned;
  logic inRange;
  logic fault;
  logic doWrite;

  assign wordAddr = req.addr[AddrWidth-1:2];
  assign offset = req.addr[1:0];
  assign size = req.func3[1:0];  // low func3 bits encode the size

  // legal codes differ by direction
  always_comb begin
    case (req.func3)
      F3Byte, F3Half, F3Word: func3Ok = 1'b1;
      F3ByteU, F3HalfU: func3Ok = !req.isStore;  // no unsigned stores
      default: func3Ok = 1'b0;
    endcase
  end

  always_comb begin
    case (size)
      2'd0: accessBytes = 3'd1;
      2'd1: accessBytes = 3'd2;
      default: accessBytes = 3'd4;
    endcase
  end

  // must stay inside one word, sum is at most 7
  assign aligned = ({1'b0, offset} + accessBytes) <= 3'd4;
  assign inRange = wordAddr < DepthLimit;
  assign fault = !(func3Ok && aligned && inRange);

  assign doWrite = reqValid && req.isStore && !fault;

  assign alignSize = size;
  assign alignOffset = offset;

  assign memWrite.byteEn = doWrite ? byteEn : 4'b0000;  // loads and faults write nothing
  assign memWrite.lanes = lanes;
  assign memWrite.wordIdx = wordAddr;

  assign rdIdx = wordAddr[IdxWidth-1:0];  // read always, result dropped if unused

  // the single pipeline stage
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      respValid <= 1'b0;
      meta <= '0;
    end else begin
      respValid <= reqValid;
      if (reqValid) begin
        meta.isLoad <= !req.isStore;
        meta.fault <= fault;
        meta.offset <= offset;
        meta.size <= size;
        meta.isUnsigned <= req.func3[2];
      end
    end
  end

  assign respFault = meta.fault;

  // every request answers on the next edge with the fault it was judged to have
  respFollowsReq: assert property (
    @(posedge clk) disable iff (!arstN)
    reqValid |=> respValid && (respFault == $past(fault))
  ) else $error("response missing or fault flag lost for the previous request");

endmodule

// File: verilog/lsuPkg.sv
package lsuPkg;

  localparam int AddrWidth = 32;  // byte address
  localparam int DataWidth = 32;
  localparam int Func3Width = 3;

  // access-size codes as carried in func3
  localparam logic [Func3Width-1:0] F3Byte = 3'd0;
  localparam logic [Func3Width-1:0] F3Half = 3'd1;
  localparam logic [Func3Width-1:0] F3Word = 3'd2;
  localparam logic [Func3Width-1:0] F3ByteU = 3'd4;  // loads only
  localparam logic [Func3Width-1:0] F3HalfU = 3'd5;  // loads only

  // one request, sampled while reqValid is high
  typedef struct packed {
    logic isStore;
    logic [Func3Width-1:0] func3;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } memReqT;

  typedef struct packed {
    logic fault;
    logic [DataWidth-1:0] rdata;  // zero for stores and faults
  } memRespT;

  // RAM write port
  // wordIdx is the full word address, the RAM decodes the low bits for its depth
  typedef struct packed {
    logic [DataWidth/8-1:0] byteEn;
    logic [DataWidth-1:0] lanes;
    logic [AddrWidth-3:0] wordIdx;
  } memWriteT;

  // travels alongside the RAM read for one cycle
  typedef struct packed {
    logic isLoad;
    logic fault;
    logic [1:0] offset;  // byte within the word
    logic [1:0] size;  // 0 byte, 1 half, 2 word
    logic isUnsigned;
  } stageMetaT;

endpackage

// File: verilog/lsuTop.sv
`timescale 1ns/1ps

module lsuTop #(
  parameter int DepthWords = 1024
) (
  input  logic clk,
  input  logic arstN,
  input  logic reqValid,
  input  lsuPkg::memReqT req,
  output logic respValid,
  output lsuPkg::memRespT resp
);
  import lsuPkg::*;

  logic [3:0] byteEn;
  logic [31:0] lanes;
  logic [1:0] alignSize;
  logic [1:0] alignOffset;
  memWriteT memWrite;
  logic [$clog2(DepthWords)-1:0] rdIdx;
  stageMetaT meta;
  logic [31:0] rdWord;

  // decode, checks and the stage register
  lsuControl #(
    .DepthWords(DepthWords)
  ) control0 (
    .clk(clk),
    .arstN(arstN),
    .reqValid(reqValid),
    .req(req),
    .byteEn(byteEn),
    .lanes(lanes),
    .alignSize(alignSize),
    .alignOffset(alignOffset),
    .memWrite(memWrite),
    .rdIdx(rdIdx),
    .meta(meta),
    .respValid(respValid),
    .respFault(resp.fault)
  );

  storeAligner aligner0 (
    .size(alignSize),
    .offset(alignOffset),
    .wdata(req.wdata),
    .byteEn(byteEn),
    .lanes(lanes)
  );

  dataMem #(
    .DepthWords(DepthWords)
  ) mem0 (
    .clk(clk),
    .memWrite(memWrite),
    .rdIdx(rdIdx),
    .rdWord(rdWord)
  );

  // works on the word read one cycle after the request
  loadExtractor extractor0 (
    .meta(meta),
    .rdWord(rdWord),
    .rdata(resp.rdata)
  );

endmodule

// File: verilog/storeAligner.sv
`timescale 1ns/1ps

module storeAligner (
  input  logic [1:0] size,
  input  logic [1:0] offset,
  input  logic [31:0] wdata,
  output logic [3:0] byteEn,
  output logic [31:0] lanes
);

  logic [31:0] sized;
  logic [3:0] baseMask;
  logic [3:0] lowBit;

  // keep only the bytes the access carries
  always_comb begin
    case (size)
      2'd0: begin
        sized = {24'b0, wdata[7:0]};  // sb
        baseMask = 4'b0001;
      end
      2'd1: begin
        sized = {16'b0, wdata[15:0]};  // sh
        baseMask = 4'b0011;
      end
      default: begin
        sized = wdata;  // sw
        baseMask = 4'b1111;
      end
    endcase
  end

  // move into the lanes picked by the low address bits
  assign lanes = sized << {offset, 3'b000};
  assign byteEn = baseMask << offset;  // spill past byte 3 is a fault upstream

  assign lowBit = byteEn & (~byteEn + 4'd1);

  // adding the lowest set bit clears a contiguous run entirely
  maskContiguous: assert final (
    (byteEn != 4'b0000) && (((byteEn + lowBit) & byteEn) == 4'b0000)
  ) else $error("byte enable mask %b is not contiguous", byteEn);

endmodule
